/* design/memMapPkg.sv */
//----------------------------------------------------------------------
// Core memory map definitions
//----------------------------------------------------------------------
package memMapPkg;

   // Address field widths
   localparam int unsigned RegionWidth = 16;
   localparam int unsigned IndexWidth  = 14;
   localparam int unsigned ByteLanes   = 4;

   // Region codes, compared against the upper address half
   localparam logic [RegionWidth-1:0] DMemRegion  = 16'h0001;
   localparam logic [RegionWidth-1:0] CrMemRegion = 16'h0002;

   // Memory depths in 32-bit words
   localparam int unsigned DMemDepth = 1024;
   localparam int unsigned IMemDepth = 32;
   localparam int unsigned CrDepth   = 16;

   // Word index widths seen by each memory
   localparam int unsigned DMemIdxWidth = $clog2(DMemDepth);
   localparam int unsigned IMemIdxWidth = $clog2(IMemDepth);
   localparam int unsigned CrIdxWidth   = $clog2(CrDepth);

   // ROM image
   localparam IMemFile = "instrMem.hex";

   //-------------------------------------------------------------------
   // Address word and its field view
   //-------------------------------------------------------------------
   // Region picks the target, index is the word within it
   typedef struct packed {
      logic [RegionWidth-1:0] region;
      logic [IndexWidth-1:0]  index;
      logic [1:0]             byteOffset;
   } t_addrFields;

   // Same 32 bits, seen raw or split into fields
   typedef union packed {
      logic [31:0] raw;
      t_addrFields fields;
   } t_memAddress;

endpackage

/* design/fpgaIoPkg.sv */
//----------------------------------------------------------------------
// Board I/O definitions
//----------------------------------------------------------------------
package fpgaIoPkg;

   // Board widths
   localparam int unsigned LedWidth    = 10;
   localparam int unsigned SwitchWidth = 10;
   localparam int unsigned Seg7Digits  = 6;
   localparam int unsigned Seg7Width   = 7;

   // Control register word offsets
   localparam int unsigned CrLedOffset     = 0;
   // First of Seg7Digits consecutive words
   localparam int unsigned CrSeg7Offset    = 1;
   localparam int unsigned CrButton0Offset = 8;
   localparam int unsigned CrButton1Offset = 9;
   localparam int unsigned CrSwitchOffset  = 10;

   // Outputs to LEDs and seven-segment digits
   typedef struct packed {
      logic [LedWidth-1:0]                  led;
      logic [Seg7Digits-1:0][Seg7Width-1:0] seg7;
   } t_fpgaOut;

   // Board inputs, sampled together
   typedef struct packed {
      logic                   button0;
      logic                   button1;
      logic [SwitchWidth-1:0] switch;
   } t_fpgaIn;

endpackage

/* design/instrMem.sv */
//----------------------------------------------------------------------
// Instruction ROM
//----------------------------------------------------------------------
`timescale 1ns/1ps

module instrMem
   import memMapPkg::*;
(
   input  logic                    Clk,
   input  logic [IMemIdxWidth-1:0] address,
   output logic [31:0]             instruction
);

   // Program image
   logic [31:0] rom [IMemDepth];

   // Loaded once at elaboration
   initial begin
      $readmemh(IMemFile, rom);
   end

   //-------------------------------------------------------------------
   // Synchronous read
   //-------------------------------------------------------------------
   // Word for the PC appears one clock later
   always_ff @(posedge Clk) begin
      instruction <= rom[address];
   end

endmodule

/* design/dataMem.sv */
//----------------------------------------------------------------------
// Data RAM with byte lanes
//----------------------------------------------------------------------
`timescale 1ns/1ps

module dataMem
   import memMapPkg::*;
(
   input  logic                    Clk,
   input  logic [DMemIdxWidth-1:0] address,
   input  logic [31:0]             wrData,
   input  logic [ByteLanes-1:0]    byteEn,
   input  logic                    wrEn,
   output logic [31:0]             rdData
);

   // Storage, one byte per lane
   logic [ByteLanes-1:0][7:0] mem [DMemDepth];

   //-------------------------------------------------------------------
   // Write port
   //-------------------------------------------------------------------
   // Each enabled lane lands at the edge, others keep their byte
   always_ff @(posedge Clk) begin
      if (wrEn) begin
         for (int lane = 0; lane < ByteLanes; lane++) begin
            if (byteEn[lane]) begin
               mem[address][lane] <= wrData[8*lane +: 8];
            end
         end
      end
   end

   //-------------------------------------------------------------------
   // Read port
   //-------------------------------------------------------------------
   // Registered read, old data on a same-cycle write
   always_ff @(posedge Clk) begin
      rdData <= mem[address];
   end

endmodule

/* design/crMem.sv */
//----------------------------------------------------------------------
// Control registers and board I/O
//----------------------------------------------------------------------
`timescale 1ns/1ps

module crMem
   import memMapPkg::*;
   import fpgaIoPkg::*;
(
   input  logic                   Clk,
   input  logic                   Rst,
   input  logic [CrIdxWidth-1:0]  address,
   input  logic [31:0]            wrData,
   input  logic                   wrEn,
   input  logic                   rdEn,
   output logic [31:0]            rdData,
   input  logic                   button0,
   input  logic                   button1,
   input  logic [SwitchWidth-1:0] switch,
   output t_fpgaOut               fpgaOut
);

   // Raw board inputs, asynchronous to Clk
   t_fpgaIn boardIn;
   // First and second synchronizer stage
   t_fpgaIn syncMeta;
   t_fpgaIn syncIn;
   // Read word before the output register
   logic [31:0] rdWord;

   assign boardIn.button0 = button0;
   assign boardIn.button1 = button1;
   assign boardIn.switch  = switch;

   //-------------------------------------------------------------------
   // Input synchronizers
   //-------------------------------------------------------------------
   // Two flops, value usable two edges after the change
   always_ff @(posedge Clk) begin
      syncMeta <= boardIn;
      syncIn   <= syncMeta;
   end

   //-------------------------------------------------------------------
   // Output registers
   //-------------------------------------------------------------------
   // Whole-word writes, only the low bits kept
   always_ff @(posedge Clk) begin
      if (Rst) begin
         fpgaOut <= '0;
      end else if (wrEn) begin
         if (address == CrIdxWidth'(CrLedOffset)) begin
            fpgaOut.led <= wrData[LedWidth-1:0];
         end
         // One word per digit
         for (int d = 0; d < Seg7Digits; d++) begin
            if (address == CrIdxWidth'(CrSeg7Offset + d)) begin
               fpgaOut.seg7[d] <= wrData[Seg7Width-1:0];
            end
         end
         // Input offsets are read only, writes there fall through
      end
   end

   //-------------------------------------------------------------------
   // Read path
   //-------------------------------------------------------------------
   // Offset decode, unused words give zero
   always_comb begin
      rdWord = '0;
      if (address == CrIdxWidth'(CrLedOffset)) begin
         rdWord[LedWidth-1:0] = fpgaOut.led;
      end
      for (int d = 0; d < Seg7Digits; d++) begin
         if (address == CrIdxWidth'(CrSeg7Offset + d)) begin
            rdWord[Seg7Width-1:0] = fpgaOut.seg7[d];
         end
      end
      if (address == CrIdxWidth'(CrButton0Offset)) begin
         rdWord[0] = syncIn.button0;
      end
      if (address == CrIdxWidth'(CrButton1Offset)) begin
         rdWord[0] = syncIn.button1;
      end
      if (address == CrIdxWidth'(CrSwitchOffset)) begin
         rdWord[SwitchWidth-1:0] = syncIn.switch;
      end
   end

   // Response register, updated only on a read strobe
   always_ff @(posedge Clk) begin
      if (Rst) begin
         rdData <= '0;
      end else if (rdEn) begin
         rdData <= rdWord;
      end
   end

endmodule

/* design/coreMemWrap.sv */
//----------------------------------------------------------------------
// Core memory wrapper
//----------------------------------------------------------------------
`timescale 1ns/1ps

module coreMemWrap
   import memMapPkg::*;
   import fpgaIoPkg::*;
(
   input  logic                   Clk,
   input  logic                   Rst,
   // Fetch
   input  logic [31:0]            pcQ100H,
   output logic [31:0]            instructionQ101H,
   // Load and store
   input  t_memAddress            dMemAddressQ103H,
   input  logic [31:0]            dMemWrDataQ103H,
   input  logic [ByteLanes-1:0]   dMemByteEnQ103H,
   input  logic                   dMemWrEnQ103H,
   input  logic                   dMemRdEnQ103H,
   output logic [31:0]            dMemRdRspQ104H,
   // Board inputs
   input  logic                   button0,
   input  logic                   button1,
   input  logic [SwitchWidth-1:0] switch,
   // Board outputs
   output t_fpgaOut               fpgaOut
);

   // Response steering, carried from Q103H to Q104H
   typedef struct packed {
      logic       matchDMem;
      logic       matchCr;
      logic [1:0] byteOffset;
   } t_rspSel;

   t_memAddress          pcAddrQ100H;
   logic                 matchDMemQ103H;
   logic                 matchCrQ103H;
   logic                 dMemWrEnMatchQ103H;
   logic                 crWrEnQ103H;
   logic                 crRdEnQ103H;
   logic [31:0]          shiftWrDataQ103H;
   logic [ByteLanes-1:0] shiftByteEnQ103H;
   t_rspSel              rspSelQ103H;
   t_rspSel              rspSelQ104H;
   logic [31:0]          dMemRawQ104H;
   logic [31:0]          dMemAlignedQ104H;
   logic [31:0]          crRdDataQ104H;

   //-------------------------------------------------------------------
   // Region decode
   //-------------------------------------------------------------------
   assign matchDMemQ103H = (dMemAddressQ103H.fields.region == DMemRegion);
   assign matchCrQ103H   = (dMemAddressQ103H.fields.region == CrMemRegion);

   // Strobes reach a memory only inside its own region
   assign dMemWrEnMatchQ103H = dMemWrEnQ103H && matchDMemQ103H;
   assign crWrEnQ103H        = dMemWrEnQ103H && matchCrQ103H;
   assign crRdEnQ103H        = dMemRdEnQ103H && matchCrQ103H;

   //-------------------------------------------------------------------
   // Store alignment
   //-------------------------------------------------------------------
   // Shift up by the byte offset, lanes past bit 31 drop off
   assign shiftWrDataQ103H =
      dMemWrDataQ103H << {dMemAddressQ103H.fields.byteOffset, 3'b000};
   assign shiftByteEnQ103H =
      dMemByteEnQ103H << dMemAddressQ103H.fields.byteOffset;

   // Q103H to Q104H
   assign rspSelQ103H.matchDMem  = matchDMemQ103H;
   assign rspSelQ103H.matchCr    = matchCrQ103H;
   assign rspSelQ103H.byteOffset = dMemAddressQ103H.fields.byteOffset;

   always_ff @(posedge Clk) begin
      if (Rst) begin
         rspSelQ104H <= '0;
      end else begin
         rspSelQ104H <= rspSelQ103H;
      end
   end

   //-------------------------------------------------------------------
   // Read response
   //-------------------------------------------------------------------
   // Load realign, zero fill from the top
   assign dMemAlignedQ104H = dMemRawQ104H >> {rspSelQ104H.byteOffset, 3'b000};

   // Unmapped region answers zero
   always_comb begin
      if (rspSelQ104H.matchCr) begin
         dMemRdRspQ104H = crRdDataQ104H;
      end else if (rspSelQ104H.matchDMem) begin
         dMemRdRspQ104H = dMemAlignedQ104H;
      end else begin
         dMemRdRspQ104H = '0;
      end
   end

   //-------------------------------------------------------------------
   // Memories
   //-------------------------------------------------------------------
   // PC is a byte address, ROM wants the word
   assign pcAddrQ100H.raw = pcQ100H;

   instrMem instrMem_inst (
      .Clk         (Clk),
      .address     (pcAddrQ100H.fields.index[IMemIdxWidth-1:0]),
      .instruction (instructionQ101H)
   );

   dataMem dataMem_inst (
      .Clk     (Clk),
      .address (dMemAddressQ103H.fields.index[DMemIdxWidth-1:0]),
      .wrData  (shiftWrDataQ103H),
      .byteEn  (shiftByteEnQ103H),
      .wrEn    (dMemWrEnMatchQ103H),
      .rdData  (dMemRawQ104H)
   );

   // Control registers see the store word as is
   crMem crMem_inst (
      .Clk     (Clk),
      .Rst     (Rst),
      .address (dMemAddressQ103H.fields.index[CrIdxWidth-1:0]),
      .wrData  (dMemWrDataQ103H),
      .wrEn    (crWrEnQ103H),
      .rdEn    (crRdEnQ103H),
      .rdData  (crRdDataQ104H),
      .button0 (button0),
      .button1 (button1),
      .switch  (switch),
      .fpgaOut (fpgaOut)
   );

endmodule

/* bench/memWrap_sva.sv */
//----------------------------------------------------------------------
// Wrapper decode assertions
//----------------------------------------------------------------------
`timescale 1ns/1ps

module memWrapSva
   import memMapPkg::*;
   import fpgaIoPkg::*;
(
   input logic                      Clk,
   input logic                      Rst,
   input t_memAddress               dMemAddressQ103H,
   input logic                      dMemRdEnQ103H,
   input logic                      dMemWrEnQ103H,
   input logic                      crWrEnQ103H,
   input logic [31:0]               dMemRdRspQ104H,
   input t_fpgaOut                  fpgaOut,
   input logic [ByteLanes-1:0][7:0] ramWords [DMemDepth]
);

   logic                    unmappedQ103H;
   logic [DMemIdxWidth-1:0] dMemIdxQ103H;

   assign unmappedQ103H = (dMemAddressQ103H.fields.region != DMemRegion) &&
                          (dMemAddressQ103H.fields.region != CrMemRegion);
   assign dMemIdxQ103H  = dMemAddressQ103H.fields.index[DMemIdxWidth-1:0];

   // RAM word untouched by a store outside the data region
   assert property (@(posedge Clk) disable iff (Rst)
      (dMemWrEnQ103H && (dMemAddressQ103H.fields.region != DMemRegion))
         |=> (ramWords[$past(dMemIdxQ103H)] === $past(ramWords[dMemIdxQ103H])))
      else $error("store outside the data region changed the data RAM");

   // Unmapped load answers zero one cycle later
   assert property (@(posedge Clk) disable iff (Rst)
      (dMemRdEnQ103H && unmappedQ103H) |=> (dMemRdRspQ104H == '0))
      else $error("unmapped read gave a nonzero response");

   // Board outputs move only after a control register store
   assert property (@(posedge Clk) disable iff (Rst)
      $changed(fpgaOut) |-> ($past(crWrEnQ103H) || $past(Rst)))
      else $error("fpgaOut changed without a control register write");

endmodule

bind coreMemWrap memWrapSva memWrapSva_inst (
   .Clk              (Clk),
   .Rst              (Rst),
   .dMemAddressQ103H (dMemAddressQ103H),
   .dMemRdEnQ103H    (dMemRdEnQ103H),
   .dMemWrEnQ103H    (dMemWrEnQ103H),
   .crWrEnQ103H      (crWrEnQ103H),
   .dMemRdRspQ104H   (dMemRdRspQ104H),
   .fpgaOut          (fpgaOut),
   .ramWords         (dataMem_inst.mem)
);

/* bench/coreMemWrapTb.sv */
//----------------------------------------------------------------------
// Core memory wrapper testbench
//----------------------------------------------------------------------
`timescale 1ns/1ps

module coreMemWrapTb
   import memMapPkg::*;
   import fpgaIoPkg::*;
();

   // About 260 cycles of tests and reset, limit set well above
   localparam int unsigned TimeoutCycles  = 2000;
   localparam int unsigned ResetCycles    = 4;
   localparam int unsigned WordTests      = 48;
   localparam logic [15:0] UnmappedRegion = 16'h0003;

   logic                   Clk;
   logic                   Rst;
   logic [31:0]            pcQ100H;
   logic [31:0]            instructionQ101H;
   t_memAddress            dMemAddressQ103H;
   logic [31:0]            dMemWrDataQ103H;
   logic [ByteLanes-1:0]   dMemByteEnQ103H;
   logic                   dMemWrEnQ103H;
   logic                   dMemRdEnQ103H;
   logic [31:0]            dMemRdRspQ104H;
   logic                   button0;
   logic                   button1;
   logic [SwitchWidth-1:0] switch;
   t_fpgaOut               fpgaOut;

   // Reference copies of ROM, RAM and board outputs
   logic [31:0] refRom [IMemDepth];
   logic [31:0] refMem [DMemDepth];
   t_fpgaOut    expOut;
   string       curTest;
   int unsigned cycleCount = 0;
   int unsigned checkCount = 0;

   coreMemWrap coreMemWrap_inst (
      .Clk              (Clk),
      .Rst              (Rst),
      .pcQ100H          (pcQ100H),
      .instructionQ101H (instructionQ101H),
      .dMemAddressQ103H (dMemAddressQ103H),
      .dMemWrDataQ103H  (dMemWrDataQ103H),
      .dMemByteEnQ103H  (dMemByteEnQ103H),
      .dMemWrEnQ103H    (dMemWrEnQ103H),
      .dMemRdEnQ103H    (dMemRdEnQ103H),
      .dMemRdRspQ104H   (dMemRdRspQ104H),
      .button0          (button0),
      .button1          (button1),
      .switch           (switch),
      .fpgaOut          (fpgaOut)
   );

   // 20 ns period
   always #10 Clk = ~Clk;

   //-------------------------------------------------------------------
   // Failure handling
   //-------------------------------------------------------------------
   task automatic abortRun();
      $display("RESULT: FAIL");
      $fatal(1, "Simulation stopped on the first error");
   endtask

   task automatic checkEqual(input string label, input logic [63:0] expected,
                             input logic [63:0] actual);
      checkCount++;
      assert (actual === expected) else begin
         $display("CHECK FAILED %s %s: expected %h actual %h",
                  curTest, label, expected, actual);
         abortRun();
      end
   endtask

   // Run bound
   always @(posedge Clk) begin
      cycleCount++;
      if (cycleCount >= TimeoutCycles) begin
         $display("Timeout: run went past %0d cycles without finishing", TimeoutCycles);
         abortRun();
      end
   end

   //-------------------------------------------------------------------
   // Reference model
   //-------------------------------------------------------------------
   function automatic logic [31:0] addrOf(logic [15:0] region, int unsigned index,
                                          logic [1:0] offset);
      return {region, 14'(index), offset};
   endfunction

   // Byte n of the store lands in lane n+offset, if that lane exists
   function automatic void modelStore(int unsigned index, logic [1:0] offset,
                                      logic [31:0] data, logic [3:0] byteEn);
      int dst;
      for (int src = 0; src < 4; src++) begin
         dst = src + int'(offset);
         if (byteEn[src] && dst < 4) begin
            refMem[index][8*dst +: 8] = data[8*src +: 8];
         end
      end
   endfunction

   // Lane n of the word comes back as byte n-offset with zero top bytes
   function automatic logic [31:0] modelLoad(int unsigned index, logic [1:0] offset);
      logic [31:0] word;
      int          off;
      word = '0;
      off  = int'(offset);
      for (int src = off; src < 4; src++) begin
         word[8*(src-off) +: 8] = refMem[index][8*src +: 8];
      end
      return word;
   endfunction

   //-------------------------------------------------------------------
   // Bus drivers
   //-------------------------------------------------------------------
   // Drives change 2 ns after the edge
   task automatic tick();
      @(posedge Clk);
      #2;
   endtask

   task automatic storeAt(input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] byteEn);
      dMemAddressQ103H.raw = addr;
      dMemWrDataQ103H      = data;
      dMemByteEnQ103H      = byteEn;
      dMemWrEnQ103H        = 1'b1;
      dMemRdEnQ103H        = 1'b0;
      tick();
      dMemWrEnQ103H        = 1'b0;
   endtask

   // Response is registered, so it is stable after the next edge
   task automatic loadAt(input logic [31:0] addr, output logic [31:0] rsp);
      dMemAddressQ103H.raw = addr;
      dMemWrEnQ103H        = 1'b0;
      dMemRdEnQ103H        = 1'b1;
      tick();
      rsp                  = dMemRdRspQ104H;
      dMemRdEnQ103H        = 1'b0;
   endtask

   //-------------------------------------------------------------------
   // Tests
   //-------------------------------------------------------------------
   task automatic testFetch();
      curTest = "testFetch";
      for (int pc = 0; pc < IMemDepth; pc++) begin
         pcQ100H = 32'(pc * 4);
         tick();
         checkEqual("instruction", refRom[pc], instructionQ101H);
      end
   endtask

   task automatic testWordAccess();
      int unsigned idx [WordTests];
      logic [31:0] data;
      logic [31:0] rsp;
      curTest = "testWordAccess";
      for (int i = 0; i < WordTests; i++) begin
         idx[i] = $urandom_range(DMemDepth - 1, 0);
         data   = $urandom();
         storeAt(addrOf(DMemRegion, idx[i], 2'd0), data, 4'hF);
         modelStore(idx[i], 2'd0, data, 4'hF);
         // Back to back with the store
         loadAt(addrOf(DMemRegion, idx[i], 2'd0), rsp);
         checkEqual("read after write", modelLoad(idx[i], 2'd0), rsp);
      end
      for (int i = 0; i < WordTests; i++) begin
         loadAt(addrOf(DMemRegion, idx[i], 2'd0), rsp);
         checkEqual("read back", modelLoad(idx[i], 2'd0), rsp);
      end
   endtask

   task automatic testByteHalf();
      int unsigned index;
      logic [31:0] data;
      logic [3:0]  byteEn;
      logic [31:0] rsp;
      curTest = "testByteHalf";
      index   = 900;
      // size 0 is a byte, size 1 a half
      for (int size = 0; size < 2; size++) begin
         for (int off = 1; off < 4; off++) begin
            byteEn = (size == 0) ? 4'b0001 : 4'b0011;
            data   = $urandom();
            // Known background so untouched lanes are checked too
            storeAt(addrOf(DMemRegion, index, 2'd0), 32'hA5A5_A5A5, 4'hF);
            modelStore(index, 2'd0, 32'hA5A5_A5A5, 4'hF);
            storeAt(addrOf(DMemRegion, index, 2'(off)), data, byteEn);
            modelStore(index, 2'(off), data, byteEn);
            loadAt(addrOf(DMemRegion, index, 2'(off)), rsp);
            checkEqual("shifted load", modelLoad(index, 2'(off)), rsp);
            loadAt(addrOf(DMemRegion, index, 2'd0), rsp);
            checkEqual("whole word", modelLoad(index, 2'd0), rsp);
            index++;
         end
      end
   endtask

   task automatic testControlRegs();
      logic [31:0] data;
      logic [31:0] rsp;
      curTest = "testControlRegs";
      data = $urandom();
      storeAt(addrOf(CrMemRegion, CrLedOffset, 2'd0), data, 4'hF);
      expOut.led = data[LedWidth-1:0];
      checkEqual("led output", expOut, fpgaOut);
      loadAt(addrOf(CrMemRegion, CrLedOffset, 2'd0), rsp);
      checkEqual("led read", 32'(expOut.led), rsp);
      // One word per digit
      for (int d = 0; d < Seg7Digits; d++) begin
         data = $urandom();
         storeAt(addrOf(CrMemRegion, CrSeg7Offset + d, 2'd0), data, 4'hF);
         expOut.seg7[d] = data[Seg7Width-1:0];
         checkEqual("seg7 output", expOut, fpgaOut);
         loadAt(addrOf(CrMemRegion, CrSeg7Offset + d, 2'd0), rsp);
         checkEqual("seg7 read", 32'(expOut.seg7[d]), rsp);
      end
      for (int round = 0; round < 2; round++) begin
         switch  = SwitchWidth'($urandom());
         button0 = (round == 0);
         button1 = (round != 0);
         // Synchronizer delay
         repeat (3) tick();
         loadAt(addrOf(CrMemRegion, CrSwitchOffset, 2'd0), rsp);
         checkEqual("switch read", 32'(switch), rsp);
         loadAt(addrOf(CrMemRegion, CrButton0Offset, 2'd0), rsp);
         checkEqual("button0 read", 32'(button0), rsp);
         loadAt(addrOf(CrMemRegion, CrButton1Offset, 2'd0), rsp);
         checkEqual("button1 read", 32'(button1), rsp);
         // Input offsets ignore stores
         storeAt(addrOf(CrMemRegion, CrSwitchOffset, 2'd0), 32'hFFFF_FFFF, 4'hF);
         storeAt(addrOf(CrMemRegion, CrButton0Offset, 2'd0), 32'hFFFF_FFFF, 4'hF);
         storeAt(addrOf(CrMemRegion, CrButton1Offset, 2'd0), 32'hFFFF_FFFF, 4'hF);
         checkEqual("outputs after input store", expOut, fpgaOut);
         loadAt(addrOf(CrMemRegion, CrSwitchOffset, 2'd0), rsp);
         checkEqual("switch after store", 32'(switch), rsp);
         loadAt(addrOf(CrMemRegion, CrButton0Offset, 2'd0), rsp);
         checkEqual("button0 after store", 32'(button0), rsp);
      end
   endtask

   task automatic testUnmapped();
      logic [31:0] rsp;
      curTest = "testUnmapped";
      storeAt(addrOf(DMemRegion, 7, 2'd0), 32'h1357_9BDF, 4'hF);
      modelStore(7, 2'd0, 32'h1357_9BDF, 4'hF);
      loadAt(addrOf(DMemRegion, 7, 2'd0), rsp);
      checkEqual("mapped load", modelLoad(7, 2'd0), rsp);
      // Nonzero response just before, so a stale value would show
      loadAt(addrOf(UnmappedRegion, 7, 2'd0), rsp);
      checkEqual("unmapped load", 32'h0, rsp);
      storeAt(addrOf(UnmappedRegion, 7, 2'd0), 32'hDEAD_BEEF, 4'hF);
      storeAt(addrOf(UnmappedRegion, CrLedOffset, 2'd0), 32'hFFFF_FFFF, 4'hF);
      checkEqual("outputs after unmapped store", expOut, fpgaOut);
      loadAt(addrOf(DMemRegion, 7, 2'd0), rsp);
      checkEqual("data after unmapped store", modelLoad(7, 2'd0), rsp);
      loadAt(addrOf(UnmappedRegion, 0, 2'd2), rsp);
      checkEqual("unmapped offset load", 32'h0, rsp);
   endtask

   task automatic testResetState();
      logic [31:0] rsp;
      curTest = "testResetState";
      loadAt(addrOf(DMemRegion, 7, 2'd0), rsp);
      Rst = 1'b1;
      tick();
      checkEqual("outputs in reset", 64'h0, fpgaOut);
      checkEqual("response in reset", 32'h0, dMemRdRspQ104H);
      repeat (ResetCycles - 1) tick();
      Rst    = 1'b0;
      expOut = '0;
      checkEqual("outputs after reset", expOut, fpgaOut);
      loadAt(addrOf(CrMemRegion, CrLedOffset, 2'd0), rsp);
      checkEqual("led read after reset", 32'h0, rsp);
      // RAM has no reset
      loadAt(addrOf(DMemRegion, 7, 2'd0), rsp);
      checkEqual("data kept", modelLoad(7, 2'd0), rsp);
      for (int unsigned index = 900; index < 906; index++) begin
         loadAt(addrOf(DMemRegion, index, 2'd0), rsp);
         checkEqual("data kept", modelLoad(index, 2'd0), rsp);
      end
   endtask

   //-------------------------------------------------------------------
   // Main sequence
   //-------------------------------------------------------------------
   initial begin
      Clk                  = 1'b0;
      Rst                  = 1'b1;
      pcQ100H              = '0;
      dMemAddressQ103H.raw = '0;
      dMemWrDataQ103H      = '0;
      dMemByteEnQ103H      = '0;
      dMemWrEnQ103H        = 1'b0;
      dMemRdEnQ103H        = 1'b0;
      button0              = 1'b0;
      button1              = 1'b0;
      switch               = '0;
      expOut               = '0;
      void'($urandom(62569));
      $readmemh(IMemFile, refRom);
      repeat (ResetCycles) @(posedge Clk);
      #2;
      Rst = 1'b0;
      testFetch();
      testWordAccess();
      testByteHalf();
      testControlRegs();
      testUnmapped();
      testResetState();
      if (checkCount > 0) begin
         $display("RESULT: PASS");
         $finish;
      end else begin
         $display("No checks were executed");
         abortRun();
      end
   end

endmodule

/* instrMem.hex */
// One 32-bit instruction word per line, from word address 0 upward
00000093
00100113
00a00193
00010237
000202b7
00222023
00022303
002081b3
40208233
0020f2b3
0020e333
0020c3b3
00209433
0020d4b3
00412503
fff00593
00b22223
00422603
00c50463
00158593
fe359ce3
00128293
0052a023
0002a683
00d70733
00470713
00e7a023
0007a803
01080833
ff5ff06f
00000013
0000006f

/* flist.f */
design/memMapPkg.sv
design/fpgaIoPkg.sv
design/instrMem.sv
design/dataMem.sv
design/crMem.sv
design/coreMemWrap.sv
bench/memWrap_sva.sv
bench/coreMemWrapTb.sv
